//--- eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic                          cmd_valid,
    output eeprom_pkg::bus_cmd_t          cmd,
    input  eeprom_pkg::bus_rsp_t          rsp,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack_err,
    output logic [7:0]                    rdata
);
    import eeprom_pkg::*;

    typedef enum logic [9:0] {
        S_IDLE        = 10'b00_0000_0001,
        S_WRITE_START = 10'b00_0000_0010,
        S_CTRL_WRITE  = 10'b00_0000_0100,
        S_ADDR_WRITE  = 10'b00_0000_1000,
        S_DATA_WRITE  = 10'b00_0001_0000,
        S_READ_START  = 10'b00_0010_0000,
        S_CTRL_READ   = 10'b00_0100_0000,
        S_DATA_READ   = 10'b00_1000_0000,
        S_STOP        = 10'b01_0000_0000,
        S_DONE        = 10'b10_0000_0000
    } state_t;

    state_t      state;
    eeprom_req_t req;
    logic        accept;

    // device code, block select, r/w bit
    function automatic logic [7:0] ctrl_byte(input logic [ADDR_W-1:0] a, input logic rw);
        return {DEV_CODE, a[ADDR_W-1:8], rw};
    endfunction

    assign busy   = !((state == S_IDLE) || (state == S_DONE));
    assign ack    = (state == S_DONE);
    assign accept = !busy && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            cmd       <= '0;
            nack_err  <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            case (state)
                S_IDLE, S_DONE:
                begin
                    state <= S_IDLE;
                    if (accept)
                    begin
                        nack_err  <= 1'b0;
                        cmd_valid <= 1'b1;
                        cmd       <= '{op: OP_START, tx_byte: 8'h00, master_nack: 1'b0};
                        state     <= S_WRITE_START;
                    end
                end
                S_WRITE_START:
                    if (rsp.done)
                    begin
                        cmd_valid <= 1'b1;
                        cmd       <= '{op: OP_WRITE, tx_byte: ctrl_byte(req.addr, 1'b0),
                                       master_nack: 1'b0};
                        state     <= S_CTRL_WRITE;
                    end
                S_CTRL_WRITE, S_ADDR_WRITE, S_DATA_WRITE, S_CTRL_READ:
                    if (rsp.done)
                    begin
                        cmd_valid <= 1'b1;
                        if (rsp.slave_nack || (state == S_DATA_WRITE))
                        begin
                            nack_err <= rsp.slave_nack;
                            cmd      <= '{op: OP_STOP, tx_byte: 8'h00, master_nack: 1'b0};
                            state    <= S_STOP;
                        end
                        else if (state == S_CTRL_WRITE)
                        begin
                            cmd   <= '{op: OP_WRITE, tx_byte: req.addr[7:0], master_nack: 1'b0};
                            state <= S_ADDR_WRITE;
                        end
                        else if (state == S_CTRL_READ)
                        begin
                            // single byte, answered with nack
                            cmd   <= '{op: OP_READ, tx_byte: 8'hff, master_nack: 1'b1};
                            state <= S_DATA_READ;
                        end
                        else if (req.is_read)
                        begin
                            cmd   <= '{op: OP_START, tx_byte: 8'h00, master_nack: 1'b0};
                            state <= S_READ_START;
                        end
                        else
                        begin
                            cmd   <= '{op: OP_WRITE, tx_byte: req.wdata, master_nack: 1'b0};
                            state <= S_DATA_WRITE;
                        end
                    end
                S_READ_START:
                    if (rsp.done)
                    begin
                        cmd_valid <= 1'b1;
                        cmd       <= '{op: OP_WRITE, tx_byte: ctrl_byte(req.addr, 1'b1),
                                       master_nack: 1'b0};
                        state     <= S_CTRL_READ;
                    end
                S_DATA_READ:
                    if (rsp.done)
                    begin
                        cmd_valid <= 1'b1;
                        cmd       <= '{op: OP_STOP, tx_byte: 8'h00, master_nack: 1'b0};
                        state     <= S_STOP;
                    end
                S_STOP:
                    if (rsp.done)
                        state <= S_DONE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // request and read data
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.is_read <= !wr;  // wr wins
            req.addr    <= addr;
            req.wdata   <= wdata;
        end
        if ((state == S_DATA_READ) && rsp.done)
            rdata <= rsp.rx_byte;
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    // every ack closes a busy transaction
    a_ack_busy: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> (!busy && $past(busy)));

endmodule

//--- eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic en,        // low means no device answers
    input  logic scl,
    input  logic sda,
    output logic sda_pull
);
    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        tx;        // sending read data
    logic        last;
    logic [3:0]  cnt;       // scl rising edges within the byte
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [10:0] ptr;

    // block number folded into the top bits
    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b00000};
    endfunction

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= fill_byte(11'(i));
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            active   <= 1'b0;
            tx       <= 1'b0;
            last     <= 1'b0;
            cnt      <= 4'd0;
            byte_idx <= 2'd0;
            ptr      <= '0;
            sda_pull <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda)
            begin
                active   <= en;    // start or repeated start
                tx       <= 1'b0;
                last     <= 1'b0;
                cnt      <= 4'd0;
                byte_idx <= 2'd0;
                sda_pull <= 1'b0;
            end
            else if (scl_q && scl && !sda_q && sda)
            begin
                active   <= 1'b0;  // stop
                sda_pull <= 1'b0;
            end
            else if (active && !scl_q && scl)
            begin
                cnt <= cnt + 4'd1;
                if (!tx && (cnt < 4'd8))
                    shreg <= {shreg[6:0], sda};
                else if (tx && (cnt == 4'd8))
                    last <= sda;   // master nack ends the read
            end
            else if (active && scl_q && !scl)
            begin
                if ((cnt == 4'd8) && tx)
                    sda_pull <= 1'b0;
                else if (cnt == 4'd8)
                begin
                    sda_pull <= (byte_idx != 2'd0) || (shreg[7:4] == 4'b1010);
                    byte_idx <= (byte_idx == 2'd2) ? 2'd2 : byte_idx + 2'd1;
                    case (byte_idx)
                        2'd0:
                        begin
                            if (shreg[7:4] == 4'b1010)
                            begin
                                ptr[10:8] <= shreg[3:1];
                                tx        <= shreg[0];
                            end
                            else
                                active <= 1'b0;
                        end
                        2'd1: ptr[7:0] <= shreg;
                        default:
                        begin
                            mem[ptr] <= shreg;
                            ptr      <= ptr + 11'd1;
                        end
                    endcase
                end
                else if (cnt == 4'd9)
                begin
                    cnt <= 4'd0;
                    if (tx && !last)
                    begin
                        shreg    <= mem[ptr];
                        sda_pull <= !mem[ptr][7];
                        ptr      <= ptr + 11'd1;
                    end
                    else
                    begin
                        sda_pull <= 1'b0;
                        if (tx)
                            active <= 1'b0;
                    end
                end
                else if (tx && (cnt != 4'd0))
                    sda_pull <= !shreg[3'(4'd7 - cnt)];
            end
        end
    end

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    // bus timing, one scl bit is four quarters
    localparam int QUARTER_CYCLES = 2;

    // 24c16 device select code
    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam int ADDR_W = 11;

    // host request, held for the whole transaction
    typedef struct packed {
        logic              is_read;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    // byte-level bus operations
    typedef enum logic [2:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bus_op_t;

    typedef struct packed {
        bus_op_t    op;
        logic [7:0] tx_byte;
        logic       master_nack; // release sda on the ack bit of a read
    } bus_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_nack;  // ack bit sampled high after a write
        logic       done;        // one cycle per command
    } bus_rsp_t;

endpackage

//--- eeprom_wr.f
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_ctrl.sv
eeprom_wr_top.sv
eeprom_model.sv
tb_eeprom_wr.sv

//--- eeprom_wr_top.sv
`timescale 1ns/1ps

module eeprom_wr_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack_err,
    output logic                          scl,
    output logic                          sda_oe,
    input  logic                          sda_in
);
    import eeprom_pkg::*;

    logic     cmd_valid;
    bus_cmd_t cmd;
    bus_rsp_t rsp;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp       (rsp),
        .busy      (busy),
        .ack       (ack),
        .nack_err  (nack_err),
        .rdata     (rdata)
    );

    // open drain sda, resolved outside
    i2c_bit_engine u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

//--- i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  eeprom_pkg::bus_cmd_t  cmd,
    output eeprom_pkg::bus_rsp_t  rsp,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    logic          active;
    bus_op_t       op_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    logic [3:0]    bit_cnt;     // 0..7 data, 8 ack
    logic [7:0]    shreg;
    logic          master_nack_q;
    logic          slave_nack_q;
    logic          done_q;

    logic          start_cmd;
    logic          tick;
    logic          last_bit;
    logic          finish;
    logic          enter;       // a new phase begins next cycle
    logic          sample;
    bus_op_t       e_op;
    logic [1:0]    e_phase;
    logic [3:0]    e_bit;
    logic          e_mnack;
    logic          tx_bit;

    always_comb
    begin
        start_cmd = cmd_valid && !active;
        tick      = active && (qcnt == QW'(QUARTER_CYCLES - 1));
        last_bit  = (op_q == OP_START) || (op_q == OP_STOP) || (bit_cnt == 4'd8);
        finish    = tick && (phase == 2'd3) && last_bit;
        enter     = start_cmd || (tick && !finish);
        e_op      = start_cmd ? cmd.op : op_q;
        e_phase   = start_cmd ? 2'd0 : phase + 2'd1;
        e_bit     = start_cmd ? 4'd0 : ((phase == 2'd3) ? bit_cnt + 4'd1 : bit_cnt);
        e_mnack   = start_cmd ? cmd.master_nack : master_nack_q;
        tx_bit    = start_cmd ? cmd.tx_byte[7] : shreg[7];
        // middle of scl high
        sample    = enter && !start_cmd && (e_phase == 2'd2)
                    && ((op_q == OP_WRITE) || (op_q == OP_READ));
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active       <= 1'b0;
            op_q         <= OP_START;
            qcnt         <= '0;
            phase        <= 2'd0;
            bit_cnt      <= 4'd0;
            scl          <= 1'b1;
            sda_oe       <= 1'b0;
            slave_nack_q <= 1'b0;
            done_q       <= 1'b0;
        end
        else
        begin
            done_q <= finish;
            if (start_cmd)
            begin
                active       <= 1'b1;
                op_q         <= cmd.op;
                slave_nack_q <= 1'b0;
            end
            else if (finish)
                active <= 1'b0;

            if (enter)
            begin
                qcnt    <= '0;
                phase   <= e_phase;
                bit_cnt <= e_bit;
            end
            else if (active)
                qcnt <= qcnt + QW'(1);

            if (enter)
            begin
                case (e_op)
                    OP_START:
                    begin
                        // release first so a repeated start sees sda high
                        case (e_phase)
                            2'd0: sda_oe <= 1'b0;
                            2'd1: scl    <= 1'b1;
                            2'd2: sda_oe <= 1'b1;  // start edge
                            default: scl <= 1'b0;
                        endcase
                    end
                    OP_STOP:
                    begin
                        case (e_phase)
                            2'd0: sda_oe <= 1'b1;
                            2'd1: scl    <= 1'b1;
                            2'd2: sda_oe <= 1'b0;  // stop edge
                            default: scl <= 1'b1;
                        endcase
                    end
                    default:
                    begin
                        case (e_phase)
                            2'd0:
                            begin
                                if (e_bit == 4'd8)
                                    sda_oe <= (e_op == OP_READ) ? !e_mnack : 1'b0;
                                else
                                    sda_oe <= (e_op == OP_WRITE) ? !tx_bit : 1'b0;
                            end
                            2'd1: scl <= 1'b1;
                            2'd2:
                            begin
                                if (e_bit == 4'd8)
                                    slave_nack_q <= (e_op == OP_WRITE) && sda_in;
                            end
                            default: scl <= 1'b0;
                        endcase
                    end
                endcase
            end
        end
    end

    // shift register, msb first out and in
    always_ff @(posedge CLK)
    begin
        if (start_cmd)
        begin
            shreg         <= cmd.tx_byte;
            master_nack_q <= cmd.master_nack;
        end
        else if (sample && (e_bit != 4'd8))
            shreg <= {shreg[6:0], sda_in};
    end

    always_comb
    begin
        rsp.rx_byte    = shreg;
        rsp.slave_nack = slave_nack_q;
        rsp.done       = done_q;
    end

    // data may only move under a low clock outside start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_oe) && !(op_q inside {OP_START, OP_STOP}))
            |-> (!scl && !$past(scl)));

    a_no_cmd_busy: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !active);

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_eeprom_wr -f eeprom_wr.f -o sim_eeprom_wr

./obj_dir/sim_eeprom_wr > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi

//--- tb_eeprom_wr.sv
`timescale 1ns/1ps

module tb_eeprom_wr;
    import eeprom_pkg::*;

    localparam int NUM_TXNS   = 200;
    localparam int TXN_CYCLES = 700;
    localparam int MAX_CYCLES = NUM_TXNS * TXN_CYCLES;

    typedef struct packed {
        eeprom_req_t req;
        logic        nack;
    } expect_t;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic [7:0]        rdata;
    logic              busy;
    logic              ack;
    logic              nack_err;
    logic              scl;
    logic              sda_oe;
    logic              sda;
    logic              model_pull;
    logic              model_en;

    expect_t    pending[$];  // accepted and waiting for ack
    logic [7:0] shadow [0:2047];
    int         seed = 32'h6c77_117e;
    int         cycles = 0;
    int         issued = 0;
    int         acks = 0;

    assign sda = !(sda_oe || model_pull);  // open drain wire

    eeprom_wr_top u_eeprom_wr_top (.*, .sda_in(sda));

    eeprom_model u_model (.CLK, .RESET, .en(model_en), .scl, .sda, .sda_pull(model_pull));

    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ {a[10:8], 5'b00000};
    endfunction

    function automatic logic [7:0] ref_read(input logic [ADDR_W-1:0] a);
        return shadow[a];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
    endtask

    task automatic issue_txn(input logic is_rd, input logic [ADDR_W-1:0] a,
                             input logic [7:0] d, input logic exp_nack);
        expect_t e;
        e.req.is_read = is_rd;
        e.req.addr    = a;
        e.req.wdata   = d;
        e.nack        = exp_nack;
        pending.push_back(e);
        issued++;
        wr    <= !is_rd;
        rd    <= is_rd;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do
        begin
            @(posedge CLK);
            n++;
        end
        while (!ack && (n < TXN_CYCLES));
        assert (ack) else abort_run("transaction did not end with an ack pulse");
    endtask

    task automatic run_txn(input logic is_rd, input logic [ADDR_W-1:0] a,
                           input logic [7:0] d, input logic exp_nack);
        issue_txn(is_rd, a, d, exp_nack);
        wait_ack();
    endtask

    // strobes on the host port while a transaction runs
    task automatic busy_strobes(input logic is_rd, input logic [ADDR_W-1:0] a,
                                input logic [7:0] d);
        issue_txn(is_rd, a, d, 1'b0);
        @(posedge CLK);
        wr    <= 1'b1;
        wdata <= ~d;
        @(posedge CLK);
        addr  <= a ^ 11'h7ff;
        wdata <= d ^ 8'h5a;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b1;
        @(posedge CLK);
        rd <= 1'b0;
        wait_ack();
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        assert (cycles < MAX_CYCLES)
        else
            abort_run($sformatf("Timeout: test did not finish within %0d cycles", MAX_CYCLES));
    end

    // compare at every ack and track completed writes
    initial
    begin
        expect_t e;
        for (int i = 0; i < 2048; i++)
            shadow[i] = fill_byte(11'(i));
        forever
        begin
            @(posedge CLK);
            if (!RESET && ack)
            begin
                assert (pending.size() > 0) else abort_run("ack pulse with no transaction");
                e = pending.pop_front();
                acks++;
                check_value("nack_err", {7'b0, nack_err}, {7'b0, e.nack});
                if (e.req.is_read && !e.nack)
                    check_value("rdata", rdata, ref_read(e.req.addr));
                if (!e.req.is_read && !e.nack)
                    shadow[e.req.addr] = e.req.wdata;
            end
        end
    end

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] last_a;
        RESET    <= 1'b1;
        wr       <= 1'b0;
        rd       <= 1'b0;
        addr     <= '0;
        wdata    <= '0;
        model_en <= 1'b1;
        last_a   = '0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        repeat (3) @(posedge CLK);
        check_value("scl", {7'b0, scl}, 8'd1);
        check_value("sda_oe", {7'b0, sda_oe}, 8'd0);
        check_value("busy", {7'b0, busy}, 8'd0);
        check_value("ack", {7'b0, ack}, 8'd0);

        // one address in every 256 byte block
        for (int i = 0; i < 8; i++)
        begin
            a = {3'(i), 8'(i * 37)};
            run_txn(1'b0, a, 8'(i) ^ 8'hc3, 1'b0);
            run_txn(1'b1, a, 8'h00, 1'b0);
        end
        run_txn(1'b0, 11'h7ff, 8'h3c, 1'b0);
        run_txn(1'b1, 11'h7ff, 8'h00, 1'b0);

        for (int i = 0; i < 150; i++)
        begin
            r = $random(seed);
            a = (r[21:20] == 2'b00) ? last_a : r[10:0];  // revisit a recent write
            if (!r[11])
                last_a = a;
            run_txn(r[11], a, r[19:12], 1'b0);
        end

        // nobody on the bus
        model_en <= 1'b0;
        run_txn(1'b0, 11'h155, 8'hee, 1'b1);
        run_txn(1'b1, 11'h155, 8'h00, 1'b1);
        model_en <= 1'b1;
        run_txn(1'b1, 11'h155, 8'h00, 1'b0);

        busy_strobes(1'b0, 11'h2d0, 8'h81);
        busy_strobes(1'b1, 11'h2d0, 8'h00);
        run_txn(1'b1, 11'h2d0, 8'h00, 1'b0);
        run_txn(1'b1, 11'h52f, 8'h00, 1'b0);

        repeat (20) @(posedge CLK);
        if ((pending.size() == 0) && (acks == issued))
        begin
            $display("Test passed");
            $finish;
        end
        else
            abort_run($sformatf("%0d transactions issued but %0d ack pulses seen", issued, acks));
    end

endmodule
